/* harness_config.svh */
`ifndef HARNESS_CONFIG_SVH
`define HARNESS_CONFIG_SVH

// ----------------------------
// Data path
// ----------------------------
`define HARNESS_DW 32

// ----------------------------
// Region map
// ----------------------------
`define ROM_BASE   32'h0000_0000
`define ROM_WORDS  256

`define SRAM_BASE  32'h8000_0000
`define SRAM_WORDS 1024

`define CLINT_BASE 32'h0200_0000
// 64 KiB window
`define CLINT_SIZE 32'h0001_0000

// ----------------------------
// CLINT register offsets
// ----------------------------
`define CLINT_MSIP        16'h0000
`define CLINT_MTIMECMP_LO 16'h4000
`define CLINT_MTIMECMP_HI 16'h4004
`define CLINT_MTIME_LO    16'hBFF8
`define CLINT_MTIME_HI    16'hBFFC

// Upper half of every boot ROM word
`define ROM_SIG 16'hB007

`endif

/* harness_pkg.sv */
`default_nettype none

`include "harness_config.svh"

package harness_pkg;

  // Decoded target of an APB transfer
  typedef enum logic [1:0] {
    REGION_ROM,
    REGION_SRAM,
    REGION_CLINT,
    REGION_NONE
  } region_e;

  // APB completer FSM
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_RESP
  } ctrl_state_e;

  // ----------------------------
  // APB port
  // ----------------------------
  typedef struct packed {
    logic [31:0]               paddr;
    logic                      pwrite;
    logic [`HARNESS_DW-1:0]    pwdata;
    logic [`HARNESS_DW/8-1:0]  pstrb;
    logic                      psel;
    logic                      penable;
  } apb_req_t;

  typedef struct packed {
    logic [`HARNESS_DW-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
  } apb_resp_t;

  // ----------------------------
  // Internal memory port
  // ----------------------------
  // Word address is relative to the region base
  typedef struct packed {
    logic                      req;
    logic                      we;
    logic [15:0]               word_addr;
    logic [`HARNESS_DW/8-1:0]  be;
    logic [`HARNESS_DW-1:0]    wdata;
  } mem_req_t;

endpackage

`default_nettype wire

/* apb_ctrl_fsm.sv */
`default_nettype none

`include "harness_config.svh"

module apb_ctrl_fsm (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  harness_pkg::apb_req_t  apb_req_i,
  output harness_pkg::apb_resp_t apb_resp_o,
  output harness_pkg::mem_req_t  rom_req_o,
  output harness_pkg::mem_req_t  sram_req_o,
  output harness_pkg::mem_req_t  clint_req_o,
  input  logic [`HARNESS_DW-1:0] rom_rdata_i,
  input  logic [`HARNESS_DW-1:0] sram_rdata_i,
  input  logic [`HARNESS_DW-1:0] clint_rdata_i
);

  localparam logic [15:0] msip_w    = 16'(`CLINT_MSIP >> 2);
  localparam logic [15:0] cmp_lo_w  = 16'(`CLINT_MTIMECMP_LO >> 2);
  localparam logic [15:0] cmp_hi_w  = 16'(`CLINT_MTIMECMP_HI >> 2);

  harness_pkg::ctrl_state_e state_q, state_d;
  harness_pkg::region_e     region_q, region_d;
  logic                     err_q, err_d;
  logic                     illegal;
  logic                     clint_wr_ok;
  logic [31:0]              clint_offs;
  logic                     issue;
  logic                     resp_valid;
  logic [`HARNESS_DW-1:0]   rdata_sel;

  function automatic logic in_window(logic [31:0] addr, logic [31:0] base, logic [31:0] bytes);
    logic [31:0] offs;
    offs = addr - base;
    return offs < bytes;
  endfunction

  function automatic harness_pkg::mem_req_t build_req(logic hit, logic [31:0] base,
                                                      harness_pkg::apb_req_t apb);
    harness_pkg::mem_req_t r;
    logic [31:0]           offs;
    offs        = apb.paddr - base;
    r.req       = hit;
    r.we        = apb.pwrite;
    r.word_addr = offs[17:2];
    r.be        = apb.pstrb;
    r.wdata     = apb.pwdata;
    return r;
  endfunction

  // ----------------------------
  // Address decode
  // ----------------------------
  assign clint_offs  = apb_req_i.paddr - `CLINT_BASE;
  assign clint_wr_ok = clint_offs[17:2] inside {msip_w, cmp_lo_w, cmp_hi_w};

  always_comb begin
    region_d = harness_pkg::REGION_NONE;
    if (in_window(apb_req_i.paddr, `ROM_BASE, 32'(`ROM_WORDS * 4))) begin
      region_d = harness_pkg::REGION_ROM;
    end else if (in_window(apb_req_i.paddr, `SRAM_BASE, 32'(`SRAM_WORDS * 4))) begin
      region_d = harness_pkg::REGION_SRAM;
    end else if (in_window(apb_req_i.paddr, `CLINT_BASE, `CLINT_SIZE)) begin
      region_d = harness_pkg::REGION_CLINT;
    end
  end

  // Unmapped, ROM write, or write to a read-only CLINT register
  assign illegal = (region_d == harness_pkg::REGION_NONE) ||
                   (region_d == harness_pkg::REGION_ROM && apb_req_i.pwrite) ||
                   (region_d == harness_pkg::REGION_CLINT && apb_req_i.pwrite && !clint_wr_ok);

  // ----------------------------
  // FSM
  // ----------------------------
  always_comb begin
    state_d = state_q;
    err_d   = err_q;
    case (state_q)
      harness_pkg::ST_IDLE: begin
        if (apb_req_i.psel && !apb_req_i.penable) begin
          state_d = harness_pkg::ST_WAIT;
          err_d   = illegal;
        end
      end
      harness_pkg::ST_WAIT: state_d = harness_pkg::ST_RESP;
      harness_pkg::ST_RESP: state_d = harness_pkg::ST_IDLE;
      default:              state_d = harness_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= harness_pkg::ST_IDLE;
      region_q <= harness_pkg::REGION_NONE;
      err_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      err_q   <= err_d;
      // Region latched at setup, held for the read mux
      if (state_q == harness_pkg::ST_IDLE) begin
        region_q <= region_d;
      end
    end
  end

  // Single-cycle request in the first access cycle
  assign issue = (state_q == harness_pkg::ST_WAIT) && apb_req_i.psel &&
                 apb_req_i.penable && !err_q;

  assign rom_req_o   = build_req(issue && region_q == harness_pkg::REGION_ROM,
                                 `ROM_BASE, apb_req_i);
  assign sram_req_o  = build_req(issue && region_q == harness_pkg::REGION_SRAM,
                                 `SRAM_BASE, apb_req_i);
  assign clint_req_o = build_req(issue && region_q == harness_pkg::REGION_CLINT,
                                 `CLINT_BASE, apb_req_i);

  // ----------------------------
  // Response
  // ----------------------------
  always_comb begin
    case (region_q)
      harness_pkg::REGION_ROM:   rdata_sel = rom_rdata_i;
      harness_pkg::REGION_SRAM:  rdata_sel = sram_rdata_i;
      harness_pkg::REGION_CLINT: rdata_sel = clint_rdata_i;
      default:                   rdata_sel = '0;
    endcase
  end

  assign resp_valid         = (state_q == harness_pkg::ST_RESP);
  assign apb_resp_o.pready  = resp_valid;
  assign apb_resp_o.pslverr = resp_valid && err_q;
  assign apb_resp_o.prdata  = (resp_valid && !err_q && !apb_req_i.pwrite) ? rdata_sel : '0;

  a_pready_in_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
    apb_resp_o.pready |-> (apb_req_i.psel && apb_req_i.penable));

endmodule

`default_nettype wire

/* clint_timer.sv */
`default_nettype none

`include "harness_config.svh"

module clint_timer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   rtc_i,
  input  harness_pkg::mem_req_t  req_i,
  output logic [`HARNESS_DW-1:0] rdata_o,
  output logic                   timer_irq_o,
  output logic                   ipi_o
);

  localparam logic [15:0] msip_w    = 16'(`CLINT_MSIP >> 2);
  localparam logic [15:0] cmp_lo_w  = 16'(`CLINT_MTIMECMP_LO >> 2);
  localparam logic [15:0] cmp_hi_w  = 16'(`CLINT_MTIMECMP_HI >> 2);
  localparam logic [15:0] time_lo_w = 16'(`CLINT_MTIME_LO >> 2);
  localparam logic [15:0] time_hi_w = 16'(`CLINT_MTIME_HI >> 2);

  logic [2:0]             rtc_q;
  logic                   rtc_rise;
  logic [63:0]            mtime_q;
  logic [63:0]            mtimecmp_q;
  logic                   msip_q;
  logic                   irq_q;
  logic                   wr;
  logic [`HARNESS_DW-1:0] rdata_d;
  logic [`HARNESS_DW-1:0] rdata_q;

  // ----------------------------
  // RTC sync and mtime
  // ----------------------------
  // Two sync stages, third flop for edge detect
  assign rtc_rise = rtc_q[1] & ~rtc_q[2];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_q   <= '0;
      mtime_q <= '0;
      irq_q   <= 1'b0;
    end else begin
      rtc_q <= {rtc_q[1:0], rtc_i};
      if (rtc_rise) begin
        mtime_q <= mtime_q + 64'd1;
      end
      irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  // ----------------------------
  // Writable registers
  // ----------------------------
  assign wr = req_i.req && req_i.we;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
    end else if (wr) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.be[b] && req_i.word_addr == cmp_lo_w) begin
          mtimecmp_q[8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
        if (req_i.be[b] && req_i.word_addr == cmp_hi_w) begin
          mtimecmp_q[32 + 8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
      if (req_i.be[0] && req_i.word_addr == msip_w) begin
        msip_q <= req_i.wdata[0];
      end
    end
  end

  // ----------------------------
  // Register read
  // ----------------------------
  always_comb begin
    case (req_i.word_addr)
      msip_w:    rdata_d = {{(`HARNESS_DW-1){1'b0}}, msip_q};
      cmp_lo_w:  rdata_d = mtimecmp_q[31:0];
      cmp_hi_w:  rdata_d = mtimecmp_q[63:32];
      time_lo_w: rdata_d = mtime_q[31:0];
      time_hi_w: rdata_d = mtime_q[63:32];
      default:   rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req && !req_i.we) begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o     = rdata_q;
  assign timer_irq_o = irq_q;
  assign ipi_o       = msip_q;

  a_msip_to_ipi: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wr && req_i.be[0] && req_i.word_addr == msip_w) |=> (ipi_o == $past(req_i.wdata[0])));

endmodule

`default_nettype wire

/* boot_rom.sv */
`default_nettype none

`include "harness_config.svh"

module boot_rom (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  harness_pkg::mem_req_t  req_i,
  output logic [`HARNESS_DW-1:0] rdata_o
);

  localparam int unsigned aw = $clog2(`ROM_WORDS);

  logic [`HARNESS_DW-1:0] rom_mem [`ROM_WORDS];
  logic [`HARNESS_DW-1:0] rdata_q;

  // ----------------------------
  // Contents
  // ----------------------------
  // Signature on top, word index below
  for (genvar k = 0; k < `ROM_WORDS; k++) begin : g_rom_word
    assign rom_mem[k] = {`ROM_SIG, 16'(k)};
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i.req) begin
      rdata_q <= rom_mem[req_i.word_addr[aw-1:0]];
    end
  end

  assign rdata_o = rdata_q;

  a_rom_no_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i.req |-> !req_i.we);

endmodule

`default_nettype wire

/* sram_bank.sv */
`default_nettype none

`include "harness_config.svh"

module sram_bank (
  input  logic                   clk_i,
  input  harness_pkg::mem_req_t  req_i,
  output logic [`HARNESS_DW-1:0] rdata_o
);

  localparam int unsigned aw = $clog2(`SRAM_WORDS);
  localparam int unsigned nb = `HARNESS_DW / 8;

  logic [`HARNESS_DW-1:0] mem [`SRAM_WORDS];
  logic [`HARNESS_DW-1:0] rdata_q;
  logic [aw-1:0]          idx;

  assign idx = req_i.word_addr[aw-1:0];

  // ----------------------------
  // Byte-enabled write port
  // ----------------------------
  always_ff @(posedge clk_i) begin
    if (req_i.req && req_i.we) begin
      for (int b = 0; b < nb; b++) begin
        if (req_i.be[b]) begin
          mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Registered read, old data on a write
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= mem[idx];
    end
  end

  assign rdata_o = rdata_q;

  a_sram_in_range: assert property (@(posedge clk_i)
    req_i.req |-> (req_i.word_addr < 16'(`SRAM_WORDS)));

endmodule

`default_nettype wire

/* harness_top.sv */
`default_nettype none

`include "harness_config.svh"

module harness_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   rtc_i,
  input  harness_pkg::apb_req_t  apb_req_i,
  output harness_pkg::apb_resp_t apb_resp_o,
  output logic                   timer_irq_o,
  output logic                   ipi_o
);

  harness_pkg::mem_req_t  rom_req;
  harness_pkg::mem_req_t  sram_req;
  harness_pkg::mem_req_t  clint_req;
  logic [`HARNESS_DW-1:0] rom_rdata;
  logic [`HARNESS_DW-1:0] sram_rdata;
  logic [`HARNESS_DW-1:0] clint_rdata;

  // ----------------------------
  // APB completer
  // ----------------------------
  apb_ctrl_fsm i_apb_ctrl_fsm (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .apb_req_i     ( apb_req_i   ),
    .apb_resp_o    ( apb_resp_o  ),
    .rom_req_o     ( rom_req     ),
    .sram_req_o    ( sram_req    ),
    .clint_req_o   ( clint_req   ),
    .rom_rdata_i   ( rom_rdata   ),
    .sram_rdata_i  ( sram_rdata  ),
    .clint_rdata_i ( clint_rdata )
  );

  // ----------------------------
  // Targets
  // ----------------------------
  boot_rom i_boot_rom (
    .clk_i   ( clk_i     ),
    .rst_ni  ( rst_ni    ),
    .req_i   ( rom_req   ),
    .rdata_o ( rom_rdata )
  );

  sram_bank i_sram_bank (
    .clk_i   ( clk_i      ),
    .req_i   ( sram_req   ),
    .rdata_o ( sram_rdata )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( clint_req   ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

endmodule

`default_nettype wire

/* harness_checker.sv */
`default_nettype none

`include "harness_config.svh"

module harness_checker (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  harness_pkg::apb_req_t  apb_req_i,
  input  harness_pkg::apb_resp_t apb_resp_i,
  input  logic [`HARNESS_DW-1:0] exp_rdata_i,
  input  logic                   exp_err_i,
  input  logic                   exp_rdata_valid_i,
  output int unsigned            tests_o,
  output int unsigned            checks_o,
  output int unsigned            errors_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned n_tests = 0;
  int unsigned n_checks = 0;
  int unsigned n_errors = 0;
  int unsigned test_errors = 0;
  string       test_name = "";
  logic        in_xfer;
  int unsigned wait_cnt;

  // ----------------------------
  // Compare helpers
  // ----------------------------
  task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("FAILED t=%0t %s: got %h, expected %h", $time, name, act, exp);
    end
  endtask

  task automatic check_range(input string name, input logic [31:0] val,
                             input logic [31:0] lo, input logic [31:0] hi);
    n_checks++;
    if (val < lo || val > hi) begin
      n_errors++;
      $display("FAILED t=%0t %s: got %h, expected %h to %h", $time, name, val, lo, hi);
    end
  endtask

  task automatic report_failure(input string msg);
    n_errors++;
    $display("Error at t=%0t: %s", $time, msg);
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = n_errors;
  endtask

  task automatic end_test();
    n_tests++;
    if (n_errors == test_errors) begin
      $display("[pass] %s", test_name);
    end else begin
      $display("[fail] %s: %0d errors", test_name, n_errors - test_errors);
    end
  endtask

  // ----------------------------
  // Transfer monitor
  // ----------------------------
  // Cycle count starts at the setup cycle
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_xfer  <= 1'b0;
      wait_cnt <= 0;
    end else if (apb_req_i.psel && !apb_req_i.penable) begin
      in_xfer  <= 1'b1;
      wait_cnt <= 1;
    end else if (in_xfer) begin
      wait_cnt <= wait_cnt + 1;
      if (apb_resp_i.pready) begin
        in_xfer <= 1'b0;
        check_value("pready_latency", wait_cnt, 32'd2);
        check_value("pslverr", 32'(apb_resp_i.pslverr), 32'(exp_err_i));
        if (exp_rdata_valid_i) begin
          check_value("prdata", apb_resp_i.prdata, exp_rdata_i);
        end
      end else if (wait_cnt > 2) begin
        in_xfer <= 1'b0;
        report_failure("pready did not arrive within two cycles after setup");
      end
    end else if (apb_resp_i.pready) begin
      report_failure("pready was raised outside of a transfer");
    end
  end

  assign tests_o  = n_tests;
  assign checks_o = n_checks;
  assign errors_o = n_errors;

endmodule

`default_nettype wire

/* tb_harness.sv */
`default_nettype none

`include "harness_config.svh"

module tb_harness;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned num_tests = 6;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   rtc;
  harness_pkg::apb_req_t  apb_req;
  harness_pkg::apb_resp_t apb_resp;
  logic                   timer_irq;
  logic                   ipi;
  logic [31:0]            exp_rdata;
  logic                   exp_err;
  logic                   exp_valid;
  int unsigned            rtc_rises = 0;
  int unsigned            n_tests;
  int unsigned            n_checks;
  int unsigned            n_errors;
  logic [31:0]            sram_shadow [`SRAM_WORDS];
  logic [63:0]            cmp_shadow;
  logic                   msip_shadow;

  harness_top uut (
    .clk_i       ( clk       ),
    .rst_ni      ( rst_n     ),
    .rtc_i       ( rtc       ),
    .apb_req_i   ( apb_req   ),
    .apb_resp_o  ( apb_resp  ),
    .timer_irq_o ( timer_irq ),
    .ipi_o       ( ipi       )
  );

  harness_checker chk (
    .clk_i             ( clk       ),
    .rst_ni            ( rst_n     ),
    .apb_req_i         ( apb_req   ),
    .apb_resp_i        ( apb_resp  ),
    .exp_rdata_i       ( exp_rdata ),
    .exp_err_i         ( exp_err   ),
    .exp_rdata_valid_i ( exp_valid ),
    .tests_o           ( n_tests   ),
    .checks_o          ( n_checks  ),
    .errors_o          ( n_errors  )
  );

  always #4 clk = ~clk;

  // Slow real-time clock, one rising edge every 20 cycles
  always begin
    repeat (10) @(posedge clk);
    rtc <= ~rtc;
    if (!rtc) begin
      rtc_rises++;
    end
  end

  // ----------------------------
  // Reference model
  // ----------------------------
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Returns {pslverr, prdata}; mtime reads come back as zero
  function automatic logic [32:0] ref_access(input logic [31:0] addr, input logic write,
                                             input logic [31:0] wdata, input logic [3:0] strb);
    logic [31:0] offs;
    logic [31:0] rdata;
    logic        err;
    rdata = '0;
    err   = 1'b0;
    if (addr - `ROM_BASE < 32'(4 * `ROM_WORDS)) begin
      offs  = (addr - `ROM_BASE) >> 2;
      err   = write;
      rdata = {`ROM_SIG, offs[15:0]};
    end else if (addr - `SRAM_BASE < 32'(4 * `SRAM_WORDS)) begin
      offs = (addr - `SRAM_BASE) >> 2;
      if (write) begin
        sram_shadow[offs] = merge_bytes(sram_shadow[offs], wdata, strb);
      end
      rdata = sram_shadow[offs];
    end else if (addr - `CLINT_BASE < `CLINT_SIZE) begin
      offs = addr - `CLINT_BASE;
      case (offs[15:0] & 16'hFFFC)
        `CLINT_MSIP: begin
          if (write && strb[0]) begin
            msip_shadow = wdata[0];
          end
          rdata = {31'b0, msip_shadow};
        end
        `CLINT_MTIMECMP_LO: begin
          if (write) begin
            cmp_shadow[31:0] = merge_bytes(cmp_shadow[31:0], wdata, strb);
          end
          rdata = cmp_shadow[31:0];
        end
        `CLINT_MTIMECMP_HI: begin
          if (write) begin
            cmp_shadow[63:32] = merge_bytes(cmp_shadow[63:32], wdata, strb);
          end
          rdata = cmp_shadow[63:32];
        end
        default: err = write;
      endcase
    end else begin
      err = 1'b1;
    end
    if (write || err) begin
      rdata = '0;
    end
    return {err, rdata};
  endfunction

  // One APB transfer, returns the sampled prdata
  task automatic apb_transfer(input logic [31:0] addr, input logic write, input logic [31:0] wdata,
                              input logic [3:0] strb, input logic chk_data,
                              output logic [31:0] rdata);
    logic [32:0] expv;
    int unsigned n;
    expv = ref_access(addr, write, wdata, strb);
    @(posedge clk);
    apb_req.paddr   <= addr;
    apb_req.pwrite  <= write;
    apb_req.pwdata  <= wdata;
    apb_req.pstrb   <= strb;
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    exp_rdata       <= expv[31:0];
    exp_err         <= expv[32];
    exp_valid       <= chk_data;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!apb_resp.pready && n < 8);
    rdata = apb_resp.prdata;
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  // ----------------------------
  // Stimulus
  // ----------------------------
  initial begin
    logic [31:0] rd;
    logic [31:0] prev;
    int unsigned a;
    int unsigned idx [16];
    void'($urandom(32'h9d851c8c));
    rst_n       = 1'b0;
    rtc         = 1'b0;
    apb_req     = '0;
    exp_rdata   = '0;
    exp_err     = 1'b0;
    exp_valid   = 1'b0;
    cmp_shadow  = '1;
    msip_shadow = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    chk.begin_test("rom_access");
    repeat (16) begin
      a = $urandom % `ROM_WORDS;
      apb_transfer(`ROM_BASE + 4 * a, 1'b0, '0, 4'hF, 1'b1, rd);
    end
    apb_transfer(`ROM_BASE + 32'h10, 1'b1, $urandom, 4'hF, 1'b1, rd);
    chk.end_test();

    chk.begin_test("sram_byte_enable");
    for (int i = 0; i < 16; i++) begin
      idx[i] = $urandom % `SRAM_WORDS;
      apb_transfer(`SRAM_BASE + 4 * idx[i], 1'b1, $urandom, 4'hF, 1'b1, rd);
    end
    for (int i = 0; i < 16; i++) begin
      apb_transfer(`SRAM_BASE + 4 * idx[i], 1'b1, $urandom, 4'($urandom), 1'b1, rd);
    end
    for (int i = 0; i < 16; i++) begin
      apb_transfer(`SRAM_BASE + 4 * idx[i], 1'b0, '0, 4'hF, 1'b1, rd);
    end
    chk.end_test();

    chk.begin_test("error_response");
    apb_transfer(32'h1000_0000, 1'b0, '0, 4'hF, 1'b1, rd);
    apb_transfer(`ROM_BASE + 4 * `ROM_WORDS, 1'b0, '0, 4'hF, 1'b1, rd);
    apb_transfer(`SRAM_BASE + 4 * `SRAM_WORDS, 1'b1, $urandom, 4'hF, 1'b1, rd);
    apb_transfer(`CLINT_BASE + `CLINT_SIZE, 1'b0, '0, 4'hF, 1'b1, rd);
    apb_transfer(`CLINT_BASE + `CLINT_MTIME_LO, 1'b1, $urandom, 4'hF, 1'b1, rd);
    apb_transfer(`CLINT_BASE + `CLINT_MTIME_HI, 1'b1, $urandom, 4'hF, 1'b1, rd);
    apb_transfer(`SRAM_BASE + 4 * idx[0], 1'b0, '0, 4'hF, 1'b1, rd);
    chk.end_test();

    chk.begin_test("software_interrupt");
    apb_transfer(`CLINT_BASE + `CLINT_MSIP, 1'b1, 32'h1, 4'hF, 1'b1, rd);
    @(posedge clk);
    chk.check_value("ipi_o", 32'(ipi), 32'd1);
    apb_transfer(`CLINT_BASE + `CLINT_MSIP, 1'b0, '0, 4'hF, 1'b1, rd);
    apb_transfer(`CLINT_BASE + `CLINT_MSIP, 1'b1, 32'h0, 4'hF, 1'b1, rd);
    @(posedge clk);
    chk.check_value("ipi_o", 32'(ipi), 32'd0);
    apb_transfer(`CLINT_BASE + `CLINT_MSIP, 1'b0, '0, 4'hF, 1'b1, rd);
    chk.end_test();

    chk.begin_test("machine_timer");
    chk.check_value("timer_irq_o", 32'(timer_irq), 32'd0);
    prev = '0;
    repeat (4) begin
      apb_transfer(`CLINT_BASE + `CLINT_MTIME_LO, 1'b0, '0, 4'hF, 1'b0, rd);
      chk.check_range("mtime_lo", rd, prev, rtc_rises);
      prev = rd;
      repeat (30) @(posedge clk);
    end
    chk.check_range("mtime_lo", prev, 32'd1, rtc_rises);
    apb_transfer(`CLINT_BASE + `CLINT_MTIMECMP_HI, 1'b1, 32'h0, 4'hF, 1'b1, rd);
    apb_transfer(`CLINT_BASE + `CLINT_MTIMECMP_LO, 1'b1, prev - 1, 4'hF, 1'b1, rd);
    repeat (2) @(posedge clk);
    chk.check_value("timer_irq_o", 32'(timer_irq), 32'd1);
    apb_transfer(`CLINT_BASE + `CLINT_MTIMECMP_LO, 1'b0, '0, 4'hF, 1'b1, rd);
    apb_transfer(`CLINT_BASE + `CLINT_MTIMECMP_LO, 1'b1, '1, 4'hF, 1'b1, rd);
    apb_transfer(`CLINT_BASE + `CLINT_MTIMECMP_HI, 1'b1, '1, 4'hF, 1'b1, rd);
    repeat (2) @(posedge clk);
    chk.check_value("timer_irq_o", 32'(timer_irq), 32'd0);
    apb_transfer(`CLINT_BASE + `CLINT_MTIMECMP_HI, 1'b0, '0, 4'hF, 1'b1, rd);
    chk.end_test();

    // Latency itself is checked by the monitor on every transfer
    chk.begin_test("pready_timing");
    for (int i = 0; i < 8; i++) begin
      a = $urandom % `ROM_WORDS;
      apb_transfer(`ROM_BASE + 4 * a, 1'b0, '0, 4'hF, 1'b1, rd);
      apb_transfer(`SRAM_BASE + 4 * idx[i], 1'b0, '0, 4'hF, 1'b1, rd);
    end
    chk.end_test();

    repeat (4) @(posedge clk);
    $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (num_tests * 2000) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the tests did not finish", num_tests * 2000);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
harness_pkg.sv
apb_ctrl_fsm.sv
clint_timer.sv
boot_rom.sv
sram_bank.sv
harness_top.sv
harness_checker.sv
tb_harness.sv

/* Bender.yml */
package:
  name: harness

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - harness_pkg.sv
      - apb_ctrl_fsm.sv
      - clint_timer.sv
      - boot_rom.sv
      - sram_bank.sv
      - harness_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - harness_checker.sv
      - tb_harness.sv
